// File: verilog.f
+incdir+include
source/hacd_pkg.sv
source/hawk_fsm_pkg.sv
source/hawk_ctrl_unit.sv
source/hawk_pgrd_manager.sv
source/hawk_pg_writer.sv
source/hawk_top.sv
testbench/hawk_tb_properties.sv
testbench/hawk_tb.sv

// File: Makefile
# Verilator build and run for the page-translation controller testbench

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = hawk_tb
FILELIST = verilog.f
PASS_MSG = all tests passed

BIN  = obj_dir/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// File: testbench/hawk_tb.sv
// testbench for the page-translation controller
// LCG stimulus, reference ppa model, grant compare process

`timescale 1ns/1ps

`include "hawk_macros.svh"

module hawk_tb;

    // cycles allowed for any single wait
    localparam int wait_max = 200;

    logic                         clk_i;
    logic                         rst_ni;
    hacd_pkg::cpu_reqpkt_t        cpu_rd_reqpkt, cpu_wr_reqpkt;
    hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_rdpkt, hawk_cpu_ovrd_wrpkt;
    logic                         init_busy;

    logic [31:0]             lcg_state;
    // reference map, hppa to ppa in order of first request
    logic                    ref_known [`HAWK_ATT_ENTRIES];
    logic [`HAWK_PPA_W-1:0]  ref_map [`HAWK_ATT_ENTRIES];
    logic [`HAWK_PPA_W-1:0]  ref_next;
    // expected ppa per port, oldest first
    logic [`HAWK_PPA_W-1:0]  rd_exp_q [$];
    logic [`HAWK_PPA_W-1:0]  wr_exp_q [$];

    hawk_top dut0 (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .cpu_rd_reqpkt       (cpu_rd_reqpkt),
        .cpu_wr_reqpkt       (cpu_wr_reqpkt),
        .hawk_cpu_ovrd_rdpkt (hawk_cpu_ovrd_rdpkt),
        .hawk_cpu_ovrd_wrpkt (hawk_cpu_ovrd_wrpkt),
        .init_busy           (init_busy)
    );

    // 100 ns period
    always #50 clk_i = ~clk_i;

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // first sight of an hppa takes the next page, later ones reuse it
    function automatic logic [`HAWK_PPA_W-1:0] ref_ppa(input logic [`HAWK_HPPA_W-1:0] hppa);
        if (!ref_known[hppa]) begin
            ref_known[hppa] = 1'b1;
            ref_map[hppa]   = ref_next;
            ref_next        = ref_next + `HAWK_PPA_W'(1);
        end
        return ref_map[hppa];
    endfunction

    // random start, then linear probe for a mapped or unmapped hppa
    function automatic logic [`HAWK_HPPA_W-1:0] pick_hppa(input logic want_known);
        logic [31:0]             r;
        logic [`HAWK_HPPA_W-1:0] h;
        logic                    found;
        r     = lcg_next();
        h     = r[31 -: `HAWK_HPPA_W];
        found = 1'b0;
        for (int i = 0; i < `HAWK_ATT_ENTRIES; i++) begin
            if (!found) begin
                if (ref_known[h] == want_known) begin
                    found = 1'b1;
                end else begin
                    h = h + `HAWK_HPPA_W'(1);
                end
            end
        end
        return h;
    endfunction

    task automatic check_ovrd_pkt(input string name, input hacd_pkg::hawk_cpu_ovrd_pkt_t got,
                                  input hacd_pkg::hawk_cpu_ovrd_pkt_t exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // raise requests together, hold each until its grant, drop it on the next edge
    task automatic request_and_wait(input logic rd_en, input logic [`HAWK_HPPA_W-1:0] rd_hppa,
                                    input logic wr_en, input logic [`HAWK_HPPA_W-1:0] wr_hppa);
        logic rd_wait, wr_wait, rd_seen, wr_seen;
        int   n;
        @(posedge clk_i);
        if (rd_en) begin
            cpu_rd_reqpkt <= '{valid: 1'b1, hppa: rd_hppa};
            rd_exp_q.push_back(ref_ppa(rd_hppa));
        end
        if (wr_en) begin
            cpu_wr_reqpkt <= '{valid: 1'b1, hppa: wr_hppa};
            wr_exp_q.push_back(ref_ppa(wr_hppa));
        end
        rd_wait = rd_en;
        wr_wait = wr_en;
        n       = 0;
        while ((rd_wait || wr_wait) && n < wait_max) begin
            @(negedge clk_i);
            rd_seen = rd_wait && hawk_cpu_ovrd_rdpkt.allow_access;
            wr_seen = wr_wait && hawk_cpu_ovrd_wrpkt.allow_access;
            @(posedge clk_i);
            if (rd_seen) begin
                cpu_rd_reqpkt <= '0;
                rd_wait = 1'b0;
            end
            if (wr_seen) begin
                cpu_wr_reqpkt <= '0;
                wr_wait = 1'b0;
            end
            n++;
        end
        if (rd_wait || wr_wait) begin
            report_failure("timeout waiting for a grant on the CPU side");
        end
    endtask

    ////////////////////
    // grant compare
    ////////////////////

    always @(negedge clk_i) begin : grant_compare
        hacd_pkg::hawk_cpu_ovrd_pkt_t exp_pkt;
        exp_pkt.allow_access = 1'b1;
        if (rst_ni && hawk_cpu_ovrd_rdpkt.allow_access) begin
            if (rd_exp_q.size() == 0) begin
                report_failure("read grant arrived with no read request outstanding");
            end else begin
                exp_pkt.ppa = rd_exp_q.pop_front();
                check_ovrd_pkt("hawk_cpu_ovrd_rdpkt", hawk_cpu_ovrd_rdpkt, exp_pkt);
            end
        end
        if (rst_ni && hawk_cpu_ovrd_wrpkt.allow_access) begin
            if (wr_exp_q.size() == 0) begin
                report_failure("write grant arrived with no write request outstanding");
            end else begin
                exp_pkt.ppa = wr_exp_q.pop_front();
                check_ovrd_pkt("hawk_cpu_ovrd_wrpkt", hawk_cpu_ovrd_wrpkt, exp_pkt);
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        logic [31:0]             r;
        logic [`HAWK_HPPA_W-1:0] h, h2;
        int                      n;
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        cpu_rd_reqpkt = '0;
        cpu_wr_reqpkt = '0;
        lcg_state     = 32'hee2508ac;
        ref_next      = '0;
        for (int i = 0; i < `HAWK_ATT_ENTRIES; i++) begin
            ref_known[i] = 1'b0;
            ref_map[i]   = '0;
        end
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        // table clear and list reset run right after reset
        @(negedge clk_i);
        check_flag("init_busy", init_busy, 1'b1);
        n = 0;
        while (init_busy && n < wait_max) begin
            @(negedge clk_i);
            n++;
        end
        if (init_busy) begin
            report_failure("timeout waiting for init_busy to fall after reset");
        end

        // reads to new pages, each one a miss with allocation
        for (int i = 0; i < 3; i++) begin
            h = pick_hppa(1'b0);
            request_and_wait(1'b1, h, 1'b0, '0);
        end
        // hits on mapped pages, reads and writes alternating
        for (int i = 0; i < 8; i++) begin
            h = pick_hppa(1'b1);
            request_and_wait(!i[0], h, i[0], h);
        end
        // random mix of new and known pages on either port
        for (int i = 0; i < 20; i++) begin
            r = lcg_next();
            h = r[31 -: `HAWK_HPPA_W];
            request_and_wait(!r[20], h, r[20], h);
        end
        // read and write raised on the same edge, to two different mapped pages
        h  = pick_hppa(1'b1);
        h2 = h;
        for (int i = 0; i < `HAWK_ATT_ENTRIES; i++) begin
            if (h2 == h || !ref_known[h2]) begin
                h2 = h2 + `HAWK_HPPA_W'(1);
            end
        end
        request_and_wait(1'b1, h, 1'b1, h2);

        // quiet stretch so a stray grant still reaches the compare process
        repeat (10) @(negedge clk_i);
        $display("all tests passed");
        $finish;
    end

endmodule

// File: testbench/hawk_tb_properties.sv
// concurrent checks on the control unit grants and lookup level
// attached to hawk_ctrl_unit by bind

`timescale 1ns/1ps

module hawk_tb_properties (
    input logic                         clk_i,
    input logic                         rst_ni,
    input logic                         init_att,
    input logic                         init_list,
    input hacd_pkg::att_lkup_reqpkt_t   lkup_reqpkt,
    input hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_rdpkt,
    input hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_wrpkt
);

    // only one lookup in flight, so never two grants at once
    grants_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(hawk_cpu_ovrd_rdpkt.allow_access && hawk_cpu_ovrd_wrpkt.allow_access))
        else $error("read and write grants high in the same cycle");

    // no lookup while the table or free list is being set up
    no_lookup_in_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (init_att || init_list) |-> !lkup_reqpkt.lookup)
        else $error("lookup raised during initialization");

    // grants are single-cycle pulses
    rd_grant_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        hawk_cpu_ovrd_rdpkt.allow_access |=> !hawk_cpu_ovrd_rdpkt.allow_access)
        else $error("read grant held longer than one cycle");

    wr_grant_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        hawk_cpu_ovrd_wrpkt.allow_access |=> !hawk_cpu_ovrd_wrpkt.allow_access)
        else $error("write grant held longer than one cycle");

endmodule

bind hawk_ctrl_unit hawk_tb_properties u_props (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .init_att            (init_att),
    .init_list           (init_list),
    .lkup_reqpkt         (lkup_reqpkt),
    .hawk_cpu_ovrd_rdpkt (hawk_cpu_ovrd_rdpkt),
    .hawk_cpu_ovrd_wrpkt (hawk_cpu_ovrd_wrpkt)
);

// File: source/hawk_top.sv
// top level of the page-translation controller
// control unit, page read manager and page writer

`timescale 1ns/1ps

`include "hawk_macros.svh"

module hawk_top (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  hacd_pkg::cpu_reqpkt_t        cpu_rd_reqpkt,
    input  hacd_pkg::cpu_reqpkt_t        cpu_wr_reqpkt,
    output hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_rdpkt,
    output hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_wrpkt,
    output logic                         init_busy
);

    hacd_pkg::att_lkup_reqpkt_t lkup_reqpkt;
    hacd_pkg::trnsl_reqpkt_t    trnsl_reqpkt;
    hacd_pkg::tol_updpkt_t      tol_updpkt;
    hacd_pkg::att_entry_t       att_rd_entry;
    logic [`HAWK_HPPA_W-1:0]    att_rd_hppa;
    logic [`HAWK_PPA_W-1:0]     free_way;
    logic                       pgrd_mngr_ready;
    logic                       init_att, init_list;
    logic                       init_att_done, init_list_done, tbl_update_done;

    // busy through both init phases
    assign init_busy = init_att | init_list;

    hawk_ctrl_unit u_ctrl (
        .clk_i, .rst_ni, .init_att_done, .init_list_done, .tbl_update_done,
        .pgrd_mngr_ready, .trnsl_reqpkt, .tol_updpkt, .lkup_reqpkt,
        .cpu_rd_reqpkt, .cpu_wr_reqpkt, .init_att, .init_list,
        .hawk_cpu_ovrd_rdpkt, .hawk_cpu_ovrd_wrpkt
    );

    hawk_pgrd_manager u_pgrd (
        .clk_i, .rst_ni, .lkup_reqpkt, .att_rd_hppa, .att_rd_entry, .free_way,
        .pgrd_mngr_ready, .trnsl_reqpkt, .tol_updpkt
    );

    hawk_pg_writer u_writer (
        .clk_i, .rst_ni, .init_att, .init_list, .tol_updpkt, .att_rd_hppa,
        .att_rd_entry, .free_way, .init_att_done, .init_list_done, .tbl_update_done
    );

endmodule

// File: source/hawk_pg_writer.sv
// page writer: ATT storage, free-page pointer, table clear and
// free list reset after reset, table updates on allocation

`timescale 1ns/1ps

`include "hawk_macros.svh"

module hawk_pg_writer (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    init_att,
    input  logic                    init_list,
    input  hacd_pkg::tol_updpkt_t   tol_updpkt,
    // combinational read port for the read manager
    input  logic [`HAWK_HPPA_W-1:0] att_rd_hppa,
    output hacd_pkg::att_entry_t    att_rd_entry,
    output logic [`HAWK_PPA_W-1:0]  free_way,
    output logic                    init_att_done,
    output logic                    init_list_done,
    output logic                    tbl_update_done
);

    localparam logic [`HAWK_HPPA_W-1:0] last_idx = `HAWK_HPPA_W'(`HAWK_ATT_ENTRIES - 1);

    hawk_fsm_pkg::wr_op_e    wr_state_q;
    hacd_pkg::att_entry_t    att_mem [`HAWK_ATT_ENTRIES];
    logic [`HAWK_HPPA_W-1:0] clr_idx_q;
    logic [`HAWK_PPA_W-1:0]  free_ptr_q;
    logic                    att_we;
    logic [`HAWK_HPPA_W-1:0] att_wr_idx;
    hacd_pkg::att_entry_t    att_wr_entry;

    assign att_rd_entry    = att_mem[att_rd_hppa];
    assign free_way        = free_ptr_q;
    // done one cycle after the entry is written
    assign tbl_update_done = (wr_state_q == hawk_fsm_pkg::WR_UPDATE);

    ////////////////////
    // table write port
    ////////////////////

    // clear writes an invalid entry, an update writes the allocated one
    always_comb begin
        att_we       = 1'b0;
        att_wr_idx   = clr_idx_q;
        att_wr_entry = '0;
        if (wr_state_q == hawk_fsm_pkg::WR_INIT_ATT) begin
            att_we = init_att;
        end else if (wr_state_q == hawk_fsm_pkg::WR_IDLE && tol_updpkt.tbl_update) begin
            att_we       = 1'b1;
            att_wr_idx   = tol_updpkt.hppa;
            att_wr_entry = tol_updpkt.lstEntry;
        end
    end

    always_ff @(posedge clk_i) begin
        if (att_we) begin
            att_mem[att_wr_idx] <= att_wr_entry;
        end
    end

    ////////////////////
    // operation sequence
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_state_q     <= hawk_fsm_pkg::WR_INIT_ATT;
            clr_idx_q      <= '0;
            free_ptr_q     <= '0;
            init_att_done  <= 1'b0;
            init_list_done <= 1'b0;
        end else begin
            init_att_done  <= 1'b0;
            init_list_done <= 1'b0;
            case (wr_state_q)
                hawk_fsm_pkg::WR_INIT_ATT: begin
                    // one entry per cycle
                    if (init_att) begin
                        clr_idx_q <= clr_idx_q + 1'b1;
                        if (clr_idx_q == last_idx) begin
                            init_att_done <= 1'b1;
                            wr_state_q    <= hawk_fsm_pkg::WR_INIT_LIST;
                        end
                    end
                end
                hawk_fsm_pkg::WR_INIT_LIST: begin
                    if (init_list) begin
                        free_ptr_q     <= '0;
                        init_list_done <= 1'b1;
                        wr_state_q     <= hawk_fsm_pkg::WR_IDLE;
                    end
                end
                hawk_fsm_pkg::WR_IDLE: begin
                    // pointer wraps, depth equals the number of pages
                    if (tol_updpkt.tbl_update) begin
                        free_ptr_q <= free_ptr_q + 1'b1;
                        wr_state_q <= hawk_fsm_pkg::WR_UPDATE;
                    end
                end
                default: wr_state_q <= hawk_fsm_pkg::WR_IDLE;
            endcase
        end
    end

endmodule

// File: source/hawk_pgrd_manager.sv
// page read manager: ATT lookup for the latched hppa, hit result
// or free-page allocation request on a miss

`timescale 1ns/1ps

`include "hawk_macros.svh"

module hawk_pgrd_manager (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // lookup level from the control unit
    input  hacd_pkg::att_lkup_reqpkt_t lkup_reqpkt,
    // table read port in the page writer
    output logic [`HAWK_HPPA_W-1:0]    att_rd_hppa,
    input  hacd_pkg::att_entry_t       att_rd_entry,
    input  logic [`HAWK_PPA_W-1:0]     free_way,
    // status and results
    output logic                       pgrd_mngr_ready,
    output hacd_pkg::trnsl_reqpkt_t    trnsl_reqpkt,
    output hacd_pkg::tol_updpkt_t      tol_updpkt
);

    hawk_fsm_pkg::pgrd_state_e pgrd_state_q;

    // lookup hppa is held by the control unit while the lookup is up
    assign att_rd_hppa = lkup_reqpkt.hppa;

    // busy from the sampling edge until the lookup level falls
    assign pgrd_mngr_ready = (pgrd_state_q == hawk_fsm_pkg::PGRD_IDLE);

    ////////////////////
    // lookup sequence
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pgrd_state_q <= hawk_fsm_pkg::PGRD_IDLE;
            trnsl_reqpkt <= '0;
            tol_updpkt   <= '0;
        end else begin
            // both results are single-cycle pulses
            trnsl_reqpkt.allow_access <= 1'b0;
            tol_updpkt.tbl_update     <= 1'b0;

            case (pgrd_state_q)
                hawk_fsm_pkg::PGRD_IDLE: begin
                    // sample a new lookup
                    if (lkup_reqpkt.lookup) begin
                        pgrd_state_q <= hawk_fsm_pkg::PGRD_LOOKUP;
                    end
                end
                hawk_fsm_pkg::PGRD_LOOKUP: begin
                    if (att_rd_entry.valid) begin
                        // hit, hand back the mapped page
                        trnsl_reqpkt.allow_access <= 1'b1;
                        trnsl_reqpkt.ppa          <= att_rd_entry.way;
                    end else begin
                        // miss, take the next free page for this hppa
                        tol_updpkt.tbl_update     <= 1'b1;
                        tol_updpkt.hppa           <= lkup_reqpkt.hppa;
                        tol_updpkt.lstEntry.valid <= 1'b1;
                        tol_updpkt.lstEntry.way   <= free_way;
                    end
                    pgrd_state_q <= hawk_fsm_pkg::PGRD_WAIT_DROP;
                end
                hawk_fsm_pkg::PGRD_WAIT_DROP: begin
                    // the same lookup must not be serviced twice
                    if (!lkup_reqpkt.lookup) begin
                        pgrd_state_q <= hawk_fsm_pkg::PGRD_IDLE;
                    end
                end
                default: pgrd_state_q <= hawk_fsm_pkg::PGRD_IDLE;
            endcase
        end
    end

endmodule

// File: source/hawk_ctrl_unit.sv
// control unit: init sequencing, read/write arbitration with alternating
// priority, lookup request latching and registered cpu grants

`timescale 1ns/1ps

module hawk_ctrl_unit (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // page writer status
    input  logic                         init_att_done,
    input  logic                         init_list_done,
    input  logic                         tbl_update_done,
    // page read manager
    input  logic                         pgrd_mngr_ready,
    input  hacd_pkg::trnsl_reqpkt_t      trnsl_reqpkt,
    input  hacd_pkg::tol_updpkt_t        tol_updpkt,
    output hacd_pkg::att_lkup_reqpkt_t   lkup_reqpkt,
    // cpu requests
    input  hacd_pkg::cpu_reqpkt_t        cpu_rd_reqpkt,
    input  hacd_pkg::cpu_reqpkt_t        cpu_wr_reqpkt,
    // init control to the page writer
    output logic                         init_att,
    output logic                         init_list,
    // grants to the cpu side
    output hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_rdpkt,
    output hacd_pkg::hawk_cpu_ovrd_pkt_t hawk_cpu_ovrd_wrpkt
);

    hawk_fsm_pkg::ctrl_state_e    state_q, state_d;
    hacd_pkg::att_lkup_reqpkt_t   lkup_d;
    hacd_pkg::hawk_cpu_ovrd_pkt_t rd_ovrd_d, wr_ovrd_d;
    logic                         init_att_d, init_list_d;
    logic                         rd_pend, wr_pend, pick_rd;

    // a request is pending only once its previous grant pulse is gone
    assign rd_pend = cpu_rd_reqpkt.valid && !hawk_cpu_ovrd_rdpkt.allow_access;
    assign wr_pend = cpu_wr_reqpkt.valid && !hawk_cpu_ovrd_wrpkt.allow_access;

    // read wins in CHK_RD_ACTIVE, write wins in CHK_WR_ACTIVE
    assign pick_rd = (state_q == hawk_fsm_pkg::CHK_RD_ACTIVE) ? rd_pend : (rd_pend && !wr_pend);

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_d     = state_q;
        init_att_d  = init_att;
        init_list_d = init_list;
        // lookup stays latched until serviced
        lkup_d      = lkup_reqpkt;
        // grant ppa holds, allow_access is a pulse
        rd_ovrd_d   = hawk_cpu_ovrd_rdpkt;
        wr_ovrd_d   = hawk_cpu_ovrd_wrpkt;
        rd_ovrd_d.allow_access = 1'b0;
        wr_ovrd_d.allow_access = 1'b0;

        case (state_q)
            hawk_fsm_pkg::IDLE: begin
                // table clear first, then free list reset
                if (init_att_done) begin
                    init_att_d = 1'b0;
                end else if (init_list_done) begin
                    init_list_d = 1'b0;
                    state_d     = hawk_fsm_pkg::CHK_RD_ACTIVE;
                end
            end
            hawk_fsm_pkg::CHK_RD_ACTIVE, hawk_fsm_pkg::CHK_WR_ACTIVE: begin
                if (pgrd_mngr_ready && (rd_pend || wr_pend)) begin
                    lkup_d.lookup = 1'b1;
                    lkup_d.hppa   = pick_rd ? cpu_rd_reqpkt.hppa : cpu_wr_reqpkt.hppa;
                    state_d       = pick_rd ? hawk_fsm_pkg::RD_LOOKUP_ALLOCATE
                                            : hawk_fsm_pkg::WR_LOOKUP_ALLOCATE;
                end
            end
            hawk_fsm_pkg::RD_LOOKUP_ALLOCATE: begin
                if (trnsl_reqpkt.allow_access) begin
                    // hit, grant with the stored ppa
                    rd_ovrd_d.allow_access = 1'b1;
                    rd_ovrd_d.ppa          = trnsl_reqpkt.ppa;
                    lkup_d                 = '0;
                    state_d                = hawk_fsm_pkg::CHK_WR_ACTIVE;
                end else if (tol_updpkt.tbl_update) begin
                    // miss, keep the new page until the table is written
                    rd_ovrd_d.ppa = tol_updpkt.lstEntry.way;
                    state_d       = hawk_fsm_pkg::RD_TBL_UPDATE;
                end
            end
            hawk_fsm_pkg::WR_LOOKUP_ALLOCATE: begin
                if (trnsl_reqpkt.allow_access) begin
                    wr_ovrd_d.allow_access = 1'b1;
                    wr_ovrd_d.ppa          = trnsl_reqpkt.ppa;
                    lkup_d                 = '0;
                    state_d                = hawk_fsm_pkg::CHK_RD_ACTIVE;
                end else if (tol_updpkt.tbl_update) begin
                    wr_ovrd_d.ppa = tol_updpkt.lstEntry.way;
                    state_d       = hawk_fsm_pkg::WR_TBL_UPDATE;
                end
            end
            hawk_fsm_pkg::RD_TBL_UPDATE: begin
                if (tbl_update_done) begin
                    rd_ovrd_d.allow_access = 1'b1;
                    lkup_d                 = '0;
                    state_d                = hawk_fsm_pkg::CHK_WR_ACTIVE;
                end
            end
            hawk_fsm_pkg::WR_TBL_UPDATE: begin
                if (tbl_update_done) begin
                    wr_ovrd_d.allow_access = 1'b1;
                    lkup_d                 = '0;
                    state_d                = hawk_fsm_pkg::CHK_RD_ACTIVE;
                end
            end
            default: state_d = hawk_fsm_pkg::IDLE;
        endcase
    end

    ////////////////////
    // registers
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q             <= hawk_fsm_pkg::IDLE;
            lkup_reqpkt         <= '0;
            hawk_cpu_ovrd_rdpkt <= '0;
            hawk_cpu_ovrd_wrpkt <= '0;
            // init sequence starts straight out of reset
            init_att            <= 1'b1;
            init_list           <= 1'b1;
        end else begin
            state_q             <= state_d;
            lkup_reqpkt         <= lkup_d;
            hawk_cpu_ovrd_rdpkt <= rd_ovrd_d;
            hawk_cpu_ovrd_wrpkt <= wr_ovrd_d;
            init_att            <= init_att_d;
            init_list           <= init_list_d;
        end
    end

endmodule

// File: source/hawk_fsm_pkg.sv
// state encodings for the control unit, page read manager and page writer

package hawk_fsm_pkg;

    // control unit, init wait then alternating read and write priority
    typedef enum logic [2:0] {
        IDLE,
        CHK_RD_ACTIVE,
        CHK_WR_ACTIVE,
        RD_LOOKUP_ALLOCATE,
        WR_LOOKUP_ALLOCATE,
        RD_TBL_UPDATE,
        WR_TBL_UPDATE
    } ctrl_state_e;

    // read manager, one lookup in flight
    typedef enum logic [1:0] {PGRD_IDLE, PGRD_LOOKUP, PGRD_WAIT_DROP} pgrd_state_e;

    // page writer operations, init sequence first
    typedef enum logic [1:0] {WR_INIT_ATT, WR_INIT_LIST, WR_IDLE, WR_UPDATE} wr_op_e;

endpackage

// File: source/hacd_pkg.sv
// packet types exchanged between the CPU side, control unit,
// page read manager and page writer

`include "hawk_macros.svh"

package hacd_pkg;

    ////////////////////
    // cpu side
    ////////////////////

    // read or write request, held as a level until granted
    typedef struct packed {
        logic                    valid;
        logic [`HAWK_HPPA_W-1:0] hppa;
    } cpu_reqpkt_t;

    // one-cycle grant back to the cpu side
    typedef struct packed {
        logic                   allow_access;
        logic [`HAWK_PPA_W-1:0] ppa;
    } hawk_cpu_ovrd_pkt_t;

    ////////////////////
    // lookup path
    ////////////////////

    // lookup level, held by the control unit until serviced
    typedef struct packed {
        logic                    lookup;
        logic [`HAWK_HPPA_W-1:0] hppa;
    } att_lkup_reqpkt_t;

    // hit result, one-cycle pulse
    typedef struct packed {
        logic                   allow_access;
        logic [`HAWK_PPA_W-1:0] ppa;
    } trnsl_reqpkt_t;

    // one ATT entry, way is the mapped ppa
    typedef struct packed {
        logic                   valid;
        logic [`HAWK_PPA_W-1:0] way;
    } att_entry_t;

    // miss with allocation, one-cycle pulse to the writer
    typedef struct packed {
        logic                    tbl_update;
        logic [`HAWK_HPPA_W-1:0] hppa;
        att_entry_t              lstEntry;
    } tol_updpkt_t;

endpackage

// File: include/hawk_macros.svh
// address widths and table size for the page-translation controller
// shared by the packet types and the table storage

`ifndef HAWK_MACROS_SVH
`define HAWK_MACROS_SVH

////////////////////
// page addresses
////////////////////

// host page address, index into the ATT
`define HAWK_HPPA_W 4

// physical page address, also the width of the free-page pointer
`define HAWK_PPA_W 4

// ATT depth, equal to the number of free pages, so allocation never runs dry
`define HAWK_ATT_ENTRIES 16

`endif
